/* hw/palPkg.sv */
package palPkg;

	// ========================================================================
	// Widths and address map
	// ========================================================================

	// Widest palette index, module parameters may narrow it
	localparam int PAL_ADDR_BITS = 12;

	// Byte address width of the register space
	localparam int AXI_ADDR_BITS = 14;

	// Control register sits just above the palette window
	localparam logic [AXI_ADDR_BITS-1:0] CTRL_ADDR = 14'h2000;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// ========================================================================
	// Palette and video types
	// ========================================================================

	// Palette word, dark bit on top then the three channel LSBs
	typedef struct packed {
		logic       dark;
		logic       rLsb;
		logic       gLsb;
		logic       bLsb;
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} palEntry_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Pixel index from the video side
	typedef struct packed {
		logic                     valid;
		logic [PAL_ADDR_BITS-1:0] index;
	} pixReq_t;

	typedef struct packed {
		logic valid;
		rgb_t color;
	} pixOut_t;

	// CPU write into the palette memory
	// Byte enable bit 0 covers entry bits 7:0
	typedef struct packed {
		logic                     en;
		logic                     bank;
		logic [PAL_ADDR_BITS-1:0] index;
		logic [1:0]               be;
		palEntry_t                entry;
	} palWrite_t;

	// Bank in data bit 0, shadow in data bit 1
	typedef struct packed {
		logic shadow;
		logic bank;
	} palCtrl_t;

	// ========================================================================
	// AXI4-Lite channels
	// ========================================================================

	typedef struct packed {
		logic                     valid;
		logic [AXI_ADDR_BITS-1:0] addr;
	} axiAw_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic [3:0]  strb;
	} axiW_t;

	typedef struct packed {
		logic                     valid;
		logic [AXI_ADDR_BITS-1:0] addr;
	} axiAr_t;

	typedef struct packed {
		logic       valid;
		logic [1:0] resp;
	} axiB_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic [1:0]  resp;
	} axiR_t;

	// Decoded access target
	typedef enum logic {
		spacePal  = 1'b0,
		spaceCtrl = 1'b1
	} regSpace_e;

endpackage

/* hw/palRam.sv */
module palRam import palPkg::*; #(
	parameter int PAL_ADDR_BITS = palPkg::PAL_ADDR_BITS
) (
	input  logic                     CLK_48M,
	input  palWrite_t                palWr,
	input  logic [PAL_ADDR_BITS-1:0] cpuRdIndex,
	input  logic                     cpuBank,
	input  logic [PAL_ADDR_BITS-1:0] vidRdIndex,
	input  logic                     vidBank,
	output palEntry_t                cpuRdData,
	output palEntry_t                vidRdData
);

	// Both banks in one array, bank select is the top address bit
	localparam int DEPTH = 2 ** (PAL_ADDR_BITS + 1);

	palEntry_t mem [DEPTH];

	logic [PAL_ADDR_BITS:0] cpuAddr;
	logic [PAL_ADDR_BITS:0] vidAddr;

	// CPU port is single address, write takes priority over read
	assign cpuAddr = palWr.en ? {palWr.bank, palWr.index[PAL_ADDR_BITS-1:0]}
		: {cpuBank, cpuRdIndex};
	assign vidAddr = {vidBank, vidRdIndex};

	// ========================================================================
	// CPU port
	// ========================================================================

	// Read-first, byte lanes written separately
	always_ff @(posedge CLK_48M) begin
		if (palWr.en) begin
			if (palWr.be[0]) begin
				mem[cpuAddr][7:0] <= palWr.entry[7:0];
			end
			if (palWr.be[1]) begin
				mem[cpuAddr][15:8] <= palWr.entry[15:8];
			end
		end
		cpuRdData <= mem[cpuAddr];
	end

	// ========================================================================
	// Video port
	// ========================================================================

	// Same-cycle collision with a CPU write returns the old entry
	always_ff @(posedge CLK_48M) begin
		vidRdData <= mem[vidAddr];
	end

endmodule

/* hw/palAxiSlave.sv */
module palAxiSlave import palPkg::*; #(
	parameter int PAL_ADDR_BITS = palPkg::PAL_ADDR_BITS
) (
	input  logic                     CLK_48M,
	input  logic                     nRESET,
	input  axiAw_t                   aw,
	input  axiW_t                    w,
	input  axiAr_t                   ar,
	input  logic                     bready,
	input  logic                     rready,
	input  palEntry_t                cpuRdData,
	output logic                     awready,
	output logic                     wready,
	output logic                     arready,
	output axiB_t                    b,
	output axiR_t                    r,
	output palWrite_t                palWr,
	output logic [PAL_ADDR_BITS-1:0] cpuRdIndex,
	output palCtrl_t                 ctrl
);

	// One sequencer for both directions, so a single transaction at a time
	typedef enum logic [1:0] {
		stIdle,
		stWrResp,
		stRdWait,
		stRdResp
	} axiState_e;

	axiState_e  state;
	regSpace_e  wrSpace;
	regSpace_e  rdSpace;
	regSpace_e  rdSpaceQ;
	logic       wrHit;
	logic       rdHit;
	logic       rdHitQ;
	logic       wrAccept;
	logic       rdAccept;
	logic       bValid;
	logic [1:0] bResp;
	logic       rValid;
	logic [31:0] rData;
	logic [1:0] rResp;

	// Upper half of the space is control, lower half palette
	function automatic regSpace_e decodeSpace(logic [AXI_ADDR_BITS-1:0] addr);
		return addr[AXI_ADDR_BITS-1] ? spaceCtrl : spacePal;
	endfunction

	// Palette hit only inside the configured bank size
	// Control hit only on the exact register address
	function automatic logic decodeHit(logic [AXI_ADDR_BITS-1:0] addr);
		logic palHit;
		palHit = (addr >> (PAL_ADDR_BITS + 1)) == '0;
		return (decodeSpace(addr) == spacePal) ? palHit : (addr == CTRL_ADDR);
	endfunction

	assign wrSpace = decodeSpace(aw.addr);
	assign wrHit   = decodeHit(aw.addr);
	assign rdSpace = decodeSpace(ar.addr);
	assign rdHit   = decodeHit(ar.addr);

	// AW and W go together, writes win over a read in the same cycle
	assign wrAccept = (state == stIdle) && aw.valid && w.valid;
	assign rdAccept = (state == stIdle) && ar.valid && !(aw.valid && w.valid);

	assign awready = wrAccept;
	assign wready  = wrAccept;
	assign arready = rdAccept;

	// ========================================================================
	// Palette RAM CPU port
	// ========================================================================

	// Write lands in the RAM on the accepting edge
	always_comb begin
		palWr = '0;
		palWr.en = wrAccept && (wrSpace == spacePal) && wrHit && (|w.strb[1:0]);
		palWr.bank = ctrl.bank;
		palWr.index[PAL_ADDR_BITS-1:0] = aw.addr[PAL_ADDR_BITS:1];
		palWr.be = w.strb[1:0];
		palWr.entry = palEntry_t'(w.data[15:0]);
	end

	// Byte address is index times two
	assign cpuRdIndex = ar.addr[PAL_ADDR_BITS:1];

	// ========================================================================
	// Sequencer and control register
	// ========================================================================

	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			state <= stIdle;
			ctrl <= '0;
			bValid <= 1'b0;
			rValid <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					if (wrAccept) begin
						state <= stWrResp;
						bValid <= 1'b1;
						// Only the low byte lane holds control bits
						if (wrSpace == spaceCtrl && wrHit && w.strb[0]) begin
							ctrl <= palCtrl_t'(w.data[1:0]);
						end
					end else if (rdAccept) begin
						state <= stRdWait;
					end
				end
				stWrResp: begin
					// Response held until the master takes it
					if (bready) begin
						bValid <= 1'b0;
						state <= stIdle;
					end
				end
				stRdWait: begin
					// RAM output is ready this cycle
					rValid <= 1'b1;
					state <= stRdResp;
				end
				stRdResp: begin
					if (rready) begin
						rValid <= 1'b0;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Response payload, stable while valid is high
	always_ff @(posedge CLK_48M) begin
		if (wrAccept) begin
			bResp <= wrHit ? RESP_OKAY : RESP_SLVERR;
		end
		if (rdAccept) begin
			rdSpaceQ <= rdSpace;
			rdHitQ <= rdHit;
		end
		if (state == stRdWait) begin
			if (!rdHitQ) begin
				rData <= '0;
				rResp <= RESP_SLVERR;
			end else if (rdSpaceQ == spacePal) begin
				rData <= {16'd0, cpuRdData};
				rResp <= RESP_OKAY;
			end else begin
				rData <= {30'd0, ctrl};
				rResp <= RESP_OKAY;
			end
		end
	end

	always_comb begin
		b.valid = bValid;
		b.resp = bResp;
		r.valid = rValid;
		r.data = rData;
		r.resp = rResp;
	end

endmodule

/* hw/colorPipe.sv */
module colorPipe import palPkg::*; #(
	parameter int PAL_ADDR_BITS = palPkg::PAL_ADDR_BITS
) (
	input  logic                     CLK_48M,
	input  logic                     nRESET,
	input  pixReq_t                  pixIn,
	input  palCtrl_t                 ctrl,
	input  palEntry_t                vidRdData,
	output logic [PAL_ADDR_BITS-1:0] vidRdIndex,
	output logic                     vidBank,
	output pixOut_t                  pixOut
);

	// Stage 1 side band, RAM holds the entry itself
	logic       s1Valid;
	logic       s1Shadow;

	// Stage 2, 7-bit channel values, bit 6 flags underflow
	logic       s2Valid;
	logic       s2Shadow;
	logic [6:0] s2R;
	logic [6:0] s2G;
	logic [6:0] s2B;

	// Stage 3 output registers
	logic       outValid;
	rgb_t       outColor;

	// 6-bit channel is value, LSB, then value MSB repeated
	// Dark bit takes one step off
	function automatic logic [6:0] widenDark(logic [3:0] val, logic lsb, logic dark);
		return {1'b0, val, lsb, val[3]} - {6'd0, dark};
	endfunction

	// Clamp at zero, stretch to 8 bits, optional halving
	function automatic logic [7:0] expandShade(logic [6:0] chan, logic shadow);
		logic [7:0] full;
		full = chan[6] ? 8'd0 : {chan[5:0], chan[4:3]};
		return shadow ? {1'b0, full[7:1]} : full;
	endfunction

	// Bank and index go straight to the RAM, sampled on the request edge
	assign vidRdIndex = pixIn.index[PAL_ADDR_BITS-1:0];
	assign vidBank = ctrl.bank;

	// ========================================================================
	// Valid chain
	// ========================================================================

	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			outValid <= 1'b0;
		end else begin
			s1Valid <= pixIn.valid;
			s2Valid <= s1Valid;
			outValid <= s2Valid;
		end
	end

	// Shadow travels with its pixel
	always_ff @(posedge CLK_48M) begin
		s1Shadow <= ctrl.shadow;
		s2Shadow <= s1Shadow;
		// Widen and subtract dark
		s2R <= widenDark(vidRdData.r, vidRdData.rLsb, vidRdData.dark);
		s2G <= widenDark(vidRdData.g, vidRdData.gLsb, vidRdData.dark);
		s2B <= widenDark(vidRdData.b, vidRdData.bLsb, vidRdData.dark);
		// Clamp, expand, shade
		outColor.r <= expandShade(s2R, s2Shadow);
		outColor.g <= expandShade(s2G, s2Shadow);
		outColor.b <= expandShade(s2B, s2Shadow);
	end

	always_comb begin
		pixOut.valid = outValid;
		pixOut.color = outColor;
	end

endmodule

/* hw/paletteTop.sv */
module paletteTop import palPkg::*; #(
	parameter int PAL_ADDR_BITS = palPkg::PAL_ADDR_BITS
) (
	input  logic    CLK_48M,
	input  logic    nRESET,
	input  axiAw_t  aw,
	input  axiW_t   w,
	input  axiAr_t  ar,
	input  logic    bready,
	input  logic    rready,
	input  pixReq_t pixIn,
	output logic    awready,
	output logic    wready,
	output logic    arready,
	output axiB_t   b,
	output axiR_t   r,
	output pixOut_t pixOut
);

	// CPU side of the palette RAM
	palWrite_t                palWr;
	logic [PAL_ADDR_BITS-1:0] cpuRdIndex;
	palEntry_t                cpuRdData;

	// Video side of the palette RAM
	logic [PAL_ADDR_BITS-1:0] vidRdIndex;
	logic                     vidBank;
	palEntry_t                vidRdData;

	// Bank select and shadow
	palCtrl_t                 ctrl;

	// ========================================================================
	// Register access, palette memory, colour conversion
	// ========================================================================

	palAxiSlave #(.PAL_ADDR_BITS(PAL_ADDR_BITS)) uAxi (
		.CLK_48M   (CLK_48M),
		.nRESET    (nRESET),
		.aw        (aw),
		.w         (w),
		.ar        (ar),
		.bready    (bready),
		.rready    (rready),
		.cpuRdData (cpuRdData),
		.awready   (awready),
		.wready    (wready),
		.arready   (arready),
		.b         (b),
		.r         (r),
		.palWr     (palWr),
		.cpuRdIndex(cpuRdIndex),
		.ctrl      (ctrl)
	);

	// CPU reads follow the bank in the control register
	palRam #(.PAL_ADDR_BITS(PAL_ADDR_BITS)) uRam (
		.CLK_48M   (CLK_48M),
		.palWr     (palWr),
		.cpuRdIndex(cpuRdIndex),
		.cpuBank   (ctrl.bank),
		.vidRdIndex(vidRdIndex),
		.vidBank   (vidBank),
		.cpuRdData (cpuRdData),
		.vidRdData (vidRdData)
	);

	colorPipe #(.PAL_ADDR_BITS(PAL_ADDR_BITS)) uPipe (
		.CLK_48M   (CLK_48M),
		.nRESET    (nRESET),
		.pixIn     (pixIn),
		.ctrl      (ctrl),
		.vidRdData (vidRdData),
		.vidRdIndex(vidRdIndex),
		.vidBank   (vidBank),
		.pixOut    (pixOut)
	);

endmodule

/* testbench/tbPalModel.svh */
`ifndef TB_PAL_MODEL_SVH
`define TB_PAL_MODEL_SVH

// ============================================================================
// AXI4-Lite master side
// ============================================================================

// Drive one write, hold bready low for a span, and probe AR meanwhile
// Called and returns just after a falling edge
task automatic axiWrite(input logic [13:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] resp, input int hold);
	int n;
	expBResp = resp;
	aw.addr = addr;
	aw.valid = 1'b1;
	w.data = data;
	w.strb = strb;
	w.valid = 1'b1;
	// Ready is combinational, let it settle after the drive
	#1;
	while (!awready) begin
		@(negedge CLK_48M);
		#1;
	end
	@(negedge CLK_48M);
	aw.valid = 1'b0;
	w.valid = 1'b0;
	// Unmapped read offered while the response waits
	ar.addr = 14'h3ffe;
	ar.valid = 1'b1;
	for (n = 0; n < hold; n++) begin
		@(negedge CLK_48M);
	end
	ar.valid = 1'b0;
	bready = 1'b1;
	@(negedge CLK_48M);
	bready = 1'b0;
endtask

// Drive one read, hold rready low for a span, and probe AW and W meanwhile
task automatic axiRead(input logic [13:0] addr, input logic [31:0] data,
		input logic [1:0] resp, input int hold);
	int n;
	expRData = data;
	expRResp = resp;
	ar.addr = addr;
	ar.valid = 1'b1;
	#1;
	while (!arready) begin
		@(negedge CLK_48M);
		#1;
	end
	@(negedge CLK_48M);
	ar.valid = 1'b0;
	// One cycle for the RAM read
	while (!r.valid) begin
		@(negedge CLK_48M);
	end
	aw.addr = 14'h3000;
	w.data = '0;
	w.strb = '0;
	aw.valid = 1'b1;
	w.valid = 1'b1;
	for (n = 0; n < hold; n++) begin
		@(negedge CLK_48M);
	end
	aw.valid = 1'b0;
	w.valid = 1'b0;
	rready = 1'b1;
	@(negedge CLK_48M);
	rready = 1'b0;
endtask

// ============================================================================
// Colour reference
// ============================================================================

// Channel order r, g, b with value nibbles at 11:8, 7:4, 3:0
// and LSBs at 14, 13, 12, dark in bit 15
function automatic logic [23:0] expectColor(input logic [15:0] entry, input logic shadow);
	logic [23:0] res;
	int c;
	int val;
	int lsb;
	int v6;
	int v8;
	res = '0;
	for (c = 0; c < 3; c++) begin
		val = int'(entry[8 - 4 * c +: 4]);
		lsb = int'(entry[14 - c]);
		// Six bits: value, LSB, then value MSB
		v6 = val * 4 + lsb * 2 + val / 8 - int'(entry[15]);
		if (v6 < 0) begin
			v6 = 0;
		end
		// Stretch to eight bits with bits 4 and 3 below
		v8 = v6 * 4 + (v6 / 8) % 4;
		if (shadow) begin
			v8 = v8 / 2;
		end
		res[23 - 8 * c -: 8] = 8'(v8);
	end
	return res;
endfunction

`endif

/* testbench/tbPalette.sv */
module tbPalette import palPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_ENTRIES  = 32;
	localparam int NUM_PIXELS   = 64;
	localparam int NUM_BP       = 16;
	// Every write, read and pixel counted once
	localparam int TRANS_TOTAL  = 7 * NUM_ENTRIES + 5 * NUM_PIXELS + 2 * NUM_BP + 8;

	logic    CLK_48M;
	logic    nRESET;
	axiAw_t  aw;
	axiW_t   w;
	axiAr_t  ar;
	logic    bready;
	logic    rready;
	pixReq_t pixIn;
	logic    awready;
	logic    wready;
	logic    arready;
	axiB_t   b;
	axiR_t   r;
	pixOut_t pixOut;

	// Reference copy of both banks and the control register
	logic [15:0] palModel [2][4096];
	palCtrl_t    ctrlModel;
	logic [11:0] idxList [NUM_ENTRIES];

	// Expected responses are set before each transfer
	logic [1:0]  expBResp;
	logic [31:0] expRData;
	logic [1:0]  expRResp;
	logic [23:0] expColor;
	logic [23:0] expPlain;
	logic [23:0] halfPlain;
	logic        expShadow;

	assign halfPlain = {1'b0, expPlain[23:17], 1'b0, expPlain[15:9], 1'b0, expPlain[7:1]};

	paletteTop #(.PAL_ADDR_BITS(PAL_ADDR_BITS)) dut (
		.CLK_48M(CLK_48M),
		.nRESET (nRESET),
		.aw     (aw),
		.w      (w),
		.ar     (ar),
		.bready (bready),
		.rready (rready),
		.pixIn  (pixIn),
		.awready(awready),
		.wready (wready),
		.arready(arready),
		.b      (b),
		.r      (r),
		.pixOut (pixOut)
	);

	task automatic stopRun(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic valueError(input string msg);
		stopRun($sformatf("ERR %0d ns: %s", $time, msg));
	endtask

	`include "tbPalModel.svh"

	// Model side of a palette write, merging the strobed bytes
	task automatic writeEntry(input logic [11:0] index, input logic [15:0] value,
			input logic [1:0] be, input int hold);
		logic [15:0] mask;
		mask = {{8{be[1]}}, {8{be[0]}}};
		axiWrite({1'b0, index, 1'b0}, {16'd0, value}, {2'b00, be}, RESP_OKAY, hold);
		palModel[ctrlModel.bank][index] = (palModel[ctrlModel.bank][index] & ~mask)
			| (value & mask);
	endtask

	task automatic checkEntry(input logic [11:0] index, input int hold);
		axiRead({1'b0, index, 1'b0}, {16'd0, palModel[ctrlModel.bank][index]}, RESP_OKAY,
			hold);
	endtask

	task automatic setCtrl(input logic [1:0] value);
		axiWrite(CTRL_ADDR, {30'd0, value}, 4'h1, RESP_OKAY, 0);
		ctrlModel = palCtrl_t'(value);
	endtask

	// First pass walks the list in order and the rest pick at random
	task automatic streamPixels(input int count, input bit gaps);
		int n;
		logic [11:0] idx;
		logic [15:0] entry;
		for (n = 0; n < count; n++) begin
			if (gaps && $urandom_range(0, 3) == 0) begin
				pixIn.valid = 1'b0;
				@(negedge CLK_48M);
			end
			idx = (n < NUM_ENTRIES) ? idxList[n] : idxList[$urandom_range(0, NUM_ENTRIES - 1)];
			entry = palModel[ctrlModel.bank][idx];
			pixIn.index = idx;
			pixIn.valid = 1'b1;
			expPlain = expectColor(entry, 1'b0);
			expColor = expectColor(entry, ctrlModel.shadow);
			expShadow = ctrlModel.shadow;
			@(negedge CLK_48M);
		end
		pixIn.valid = 1'b0;
		// Drain the three stages
		repeat (3) @(negedge CLK_48M);
	endtask

	// ========================================================================
	// Checks
	// ========================================================================

	assert property (@(posedge CLK_48M) !nRESET |-> (!pixOut.valid && !b.valid && !r.valid
		&& !awready && !wready && !arready))
		else stopRun("Outputs were active while reset was asserted");

	assert property (@(posedge CLK_48M) disable iff (!nRESET) b.valid |-> b.resp == expBResp)
		else valueError($sformatf("write resp %0d, expected %0d", b.resp, expBResp));

	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		r.valid |-> (r.data == expRData && r.resp == expRResp))
		else valueError($sformatf("read data %h resp %0d, expected %h resp %0d",
			r.data, r.resp, expRData, expRResp));

	// Fixed three cycle video latency
	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		pixOut.valid == $past(pixIn.valid, 3))
		else stopRun("Pixel output did not follow its request by three cycles");

	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		pixOut.valid |-> pixOut.color == $past(expColor, 3))
		else valueError($sformatf("pixel colour %h does not match the model", pixOut.color));

	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		(pixOut.valid && $past(expShadow, 3)) |-> pixOut.color == $past(halfPlain, 3))
		else valueError($sformatf("shadowed pixel %h is not half the plain colour",
			pixOut.color));

	// Responses held under back-pressure
	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		$past(b.valid && !bready) |-> (b.valid && b == $past(b)))
		else stopRun("Write response changed before it was accepted");

	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		$past(r.valid && !rready) |-> (r.valid && r == $past(r)))
		else stopRun("Read response changed before it was accepted");

	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		(b.valid || r.valid) |-> !(awready || wready || arready))
		else stopRun("A new address was accepted while a response was waiting");

	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		$past(aw.valid && awready) |-> (b.valid && !$past(b.valid)))
		else stopRun("Write response did not rise one cycle after the write");

	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		$past(ar.valid && arready, 2) |-> (r.valid && !$past(r.valid)))
		else stopRun("Read response did not rise two cycles after the address");

	// ========================================================================
	// Clock, stimulus, watchdog
	// ========================================================================

	always #(CLK_PERIOD / 2) CLK_48M = ~CLK_48M;

	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + 20 * TRANS_TOTAL));
		stopRun("Timeout: the test did not finish in time");
	end

	initial begin
		int i;
		void'($urandom(32'h7f7e));
		CLK_48M = 1'b0;
		nRESET = 1'b1;
		aw = '0;
		w = '0;
		ar = '0;
		bready = 1'b0;
		rready = 1'b0;
		pixIn = '0;
		ctrlModel = '0;
		expBResp = RESP_OKAY;
		expRData = '0;
		expRResp = RESP_OKAY;
		expColor = '0;
		expPlain = '0;
		expShadow = 1'b0;
		// Falling edge on nRESET fires the async reset before the first clock
		#5;
		nRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_48M);
		@(negedge CLK_48M);
		nRESET = 1'b1;

		// Control register starts at zero
		axiRead(CTRL_ADDR, 32'd0, RESP_OKAY, 0);

		// Full write first, then a random strobe merge, then read back
		for (i = 0; i < NUM_ENTRIES; i++) begin
			idxList[i] = 12'(i * 128 + $urandom_range(0, 127));
			writeEntry(idxList[i], 16'($urandom), 2'b11, 0);
			writeEntry(idxList[i], 16'($urandom), 2'($urandom), 0);
			checkEntry(idxList[i], 0);
		end
		axiWrite(14'h2004, 32'h3, 4'hf, RESP_SLVERR, 0);
		axiRead(14'h3ffe, 32'd0, RESP_SLVERR, 0);

		// All dark and LSB patterns with zero channels in the second half for the clamp
		for (i = 0; i < NUM_ENTRIES; i++) begin
			writeEntry(idxList[i], {4'(i), (i < 16) ? 12'($urandom) : 12'h000}, 2'b11, 0);
		end
		streamPixels(NUM_PIXELS, 1'b0);

		// Bank 1 gets the inverse of bank 0
		setCtrl(2'b01);
		for (i = 0; i < NUM_ENTRIES; i++) begin
			writeEntry(idxList[i], ~palModel[0][idxList[i]], 2'b11, 0);
		end
		for (i = 0; i < NUM_ENTRIES; i++) begin
			checkEntry(idxList[i], 0);
		end
		streamPixels(NUM_PIXELS, 1'b1);
		setCtrl(2'b00);
		for (i = 0; i < NUM_ENTRIES; i++) begin
			checkEntry(idxList[i], 0);
		end
		streamPixels(NUM_PIXELS, 1'b0);

		// Shadow on each bank
		setCtrl(2'b10);
		streamPixels(NUM_PIXELS, 1'b0);
		setCtrl(2'b11);
		streamPixels(NUM_PIXELS, 1'b1);
		axiRead(CTRL_ADDR, 32'd3, RESP_OKAY, 0);

		// Random back-pressure spans
		for (i = 0; i < NUM_BP; i++) begin
			writeEntry(idxList[i], 16'($urandom), 2'($urandom), $urandom_range(0, 7));
			checkEntry(idxList[i], $urandom_range(0, 7));
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+testbench
hw/palPkg.sv
hw/palRam.sv
hw/palAxiSlave.sv
hw/colorPipe.sv
hw/paletteTop.sv
testbench/tbPalette.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tbPalette -f verilog.f --Mdir obj_dir -o vtbPalette
	./obj_dir/vtbPalette | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
